// File: src.f
+incdir+include
rtl/mem_arb_pkg.sv
rtl/imem_port_arbiter.sv
rtl/mem_port_arbiter.sv
rtl/dual_core_mem_arbiter.sv
verification/dual_core_mem_arbiter_chk.sv
verification/dual_core_mem_arbiter_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := dual_core_mem_arbiter_tb
FILELIST  := src.f
VFLAGS    := --binary --assert --timing --timescale 1ns/1ps -j 0
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := TEST OK

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/dual_core_mem_arbiter_tb.sv
/* dual core memory arbiter testbench
   directed tests checked against a cycle model of both priority rotations */

`timescale 1ns/1ps

`include "mem_arb_cfg.svh"

module dual_core_mem_arbiter_tb
	import mem_arb_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 1000;
	localparam int WIN_NONE = 0;
	localparam int WIN_CORE0 = 1;
	localparam int WIN_CORE1 = 2;
	localparam int WIN_DMEM = 3;

	logic						clk;
	logic						rst;
	imem_req_t					core0_req;
	imem_req_t					core1_req;
	dmem_req_t					dmem_req;
	logic	[`MEM_TAG_W-1:0]	mem_response;
	mem_cmd_e					mem_cmd;
	logic	[`MEM_ADDR_W-1:0]	mem_addr;
	logic	[`MEM_DATA_W-1:0]	mem_data;
	logic	[`MEM_TAG_W-1:0]	core0_response;
	logic	[`MEM_TAG_W-1:0]	core1_response;
	logic	[`MEM_TAG_W-1:0]	dmem_response;

	// cycle n since reset release and total cycles for the timeout
	int				n_cnt = 0;
	int				cycle_cnt = 0;
	int				err_cnt;
	logic	[31:0]	rng;

	dual_core_mem_arbiter UUT (
		.clk				(clk),
		.rst				(rst),
		.core0_imem_req_i	(core0_req),
		.core1_imem_req_i	(core1_req),
		.dmem_req_i			(dmem_req),
		.mem_response_i		(mem_response),
		.mem_cmd_o			(mem_cmd),
		.mem_addr_o			(mem_addr),
		.mem_data_o			(mem_data),
		.core0_response_o	(core0_response),
		.core1_response_o	(core1_response),
		.dmem_response_o	(dmem_response)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			n_cnt <= 0;
		end else begin
			n_cnt <= n_cnt + 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles before the tests completed", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	//--------------------------------------------------
	// random stimulus
	//--------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic rand_word(output logic [63:0] w);
		rng = xorshift(rng);
		w[63:32] = rng;
		rng = xorshift(rng);
		w[31:0] = rng;
	endtask

	task automatic rand_tag(output logic [`MEM_TAG_W-1:0] t);
		rng = xorshift(rng);
		t = rng[`MEM_TAG_W-1:0];
		// zero tag would look like no response
		if (t == '0) begin
			t[0] = 1'b1;
		end
	endtask

	task automatic rand_imem(output imem_req_t r);
		logic [63:0] w;
		rand_word(w);
		r.cmd = MEM_LOAD;
		r.addr = w;
	endtask

	task automatic rand_dmem(input mem_cmd_e cmd, output dmem_req_t r);
		logic [63:0] w;
		rand_word(w);
		r.cmd = cmd;
		r.addr = w;
		rand_word(w);
		r.data = w;
	endtask

	//--------------------------------------------------
	// reference model and checks
	//--------------------------------------------------
	// winner of cycle n from the two rotation rules
	function automatic int predict_winner(input int n, input logic c0_v, input logic c1_v,
		input logic d_v);
		logic	core1_pref;
		logic	inst_first;
		int		inst_win;
		core1_pref = (n % 2) == 1;
		inst_first = (n % `MEM_ABT_PERIOD) == 0;
		if (c0_v && c1_v) begin
			inst_win = core1_pref ? WIN_CORE1 : WIN_CORE0;
		end else if (c1_v) begin
			inst_win = WIN_CORE1;
		end else begin
			inst_win = c0_v ? WIN_CORE0 : WIN_NONE;
		end
		if (inst_first) begin
			return (inst_win != WIN_NONE) ? inst_win : (d_v ? WIN_DMEM : WIN_NONE);
		end
		return d_v ? WIN_DMEM : inst_win;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_cycle();
		int		win;
		logic	[`MEM_TAG_W-1:0]	exp_c0;
		logic	[`MEM_TAG_W-1:0]	exp_c1;
		logic	[`MEM_TAG_W-1:0]	exp_d;
		win = predict_winner(n_cnt, core0_req.cmd != MEM_NONE, core1_req.cmd != MEM_NONE,
			dmem_req.cmd != MEM_NONE);
		exp_c0 = (win == WIN_CORE0) ? mem_response : '0;
		exp_c1 = (win == WIN_CORE1) ? mem_response : '0;
		exp_d = (win == WIN_DMEM) ? mem_response : '0;
		case (win)
			WIN_CORE0: begin
				check_value("mem_cmd_o", 64'(core0_req.cmd), 64'(mem_cmd));
				check_value("mem_addr_o", core0_req.addr, mem_addr);
			end
			WIN_CORE1: begin
				check_value("mem_cmd_o", 64'(core1_req.cmd), 64'(mem_cmd));
				check_value("mem_addr_o", core1_req.addr, mem_addr);
			end
			WIN_DMEM: begin
				check_value("mem_cmd_o", 64'(dmem_req.cmd), 64'(mem_cmd));
				check_value("mem_addr_o", dmem_req.addr, mem_addr);
			end
			default: check_value("mem_cmd_o", 64'(MEM_NONE), 64'(mem_cmd));
		endcase
		check_value("mem_data_o", dmem_req.data, mem_data);
		check_value("core0_response_o", 64'(exp_c0), 64'(core0_response));
		check_value("core1_response_o", 64'(exp_c1), 64'(core1_response));
		check_value("dmem_response_o", 64'(exp_d), 64'(dmem_response));
	endtask

	// drive on the falling edge and check just before the rising edge
	task automatic run_cycle(input imem_req_t c0, input imem_req_t c1, input dmem_req_t d,
		input logic [`MEM_TAG_W-1:0] tag);
		@(negedge clk);
		core0_req = c0;
		core1_req = c1;
		dmem_req = d;
		mem_response = tag;
		#1;
		check_cycle();
	endtask

	//--------------------------------------------------
	// tests
	//--------------------------------------------------
	task automatic idle_and_reset();
		imem_req_t	idle_i;
		dmem_req_t	idle_d;
		idle_i = '0;
		idle_d = '0;
		// rst is high from time zero and falls after 8 rising edges
		repeat (7) run_cycle(idle_i, idle_i, idle_d, '1);
		@(negedge clk);
		rst = 1'b0;
		#1;
		check_cycle();
		repeat (8) run_cycle(idle_i, idle_i, idle_d, '1);
	endtask

	task automatic single_requester();
		imem_req_t	req_i;
		imem_req_t	idle_i;
		dmem_req_t	req_d;
		dmem_req_t	idle_d;
		logic	[`MEM_TAG_W-1:0]	tag;
		int		i;
		idle_i = '0;
		idle_d = '0;
		for (i = 0; i < 12; i++) begin
			rand_imem(req_i);
			rand_tag(tag);
			run_cycle(req_i, idle_i, idle_d, tag);
		end
		for (i = 0; i < 12; i++) begin
			rand_imem(req_i);
			rand_tag(tag);
			run_cycle(idle_i, req_i, idle_d, tag);
		end
		for (i = 0; i < 12; i++) begin
			rand_dmem((i % 2 == 1) ? MEM_STORE : MEM_LOAD, req_d);
			rand_tag(tag);
			run_cycle(idle_i, idle_i, req_d, tag);
		end
	endtask

	task automatic core_contention();
		imem_req_t	req0;
		imem_req_t	req1;
		dmem_req_t	idle_d;
		logic	[`MEM_TAG_W-1:0]	tag;
		idle_d = '0;
		repeat (24) begin
			rand_imem(req0);
			rand_imem(req1);
			rand_tag(tag);
			run_cycle(req0, req1, idle_d, tag);
		end
	endtask

	task automatic inst_vs_data();
		imem_req_t	req_i;
		imem_req_t	idle_i;
		dmem_req_t	req_d;
		logic	[`MEM_TAG_W-1:0]	tag;
		idle_i = '0;
		repeat (24) begin
			rand_imem(req_i);
			rand_dmem(MEM_LOAD, req_d);
			rand_tag(tag);
			run_cycle(req_i, idle_i, req_d, tag);
		end
		repeat (24) begin
			rand_imem(req_i);
			rand_dmem(MEM_STORE, req_d);
			rand_tag(tag);
			run_cycle(idle_i, req_i, req_d, tag);
		end
	endtask

	task automatic all_three_store();
		imem_req_t	req0;
		imem_req_t	req1;
		dmem_req_t	req_d;
		logic	[`MEM_TAG_W-1:0]	tag;
		repeat (32) begin
			rand_imem(req0);
			rand_imem(req1);
			rand_dmem(MEM_STORE, req_d);
			rand_tag(tag);
			run_cycle(req0, req1, req_d, tag);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		core0_req = '0;
		core1_req = '0;
		dmem_req = '0;
		mem_response = '0;
		err_cnt = 0;
		rng = 32'hb941;

		idle_and_reset();
		single_requester();
		core_contention();
		inst_vs_data();
		all_three_store();

		$display("errors: %0d check mismatches, %0d assertion failures",
			err_cnt, UUT.chk.fail_cnt);
		if (err_cnt == 0 && UUT.chk.fail_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule : dual_core_mem_arbiter_tb

// File: verification/dual_core_mem_arbiter_chk.sv
/* arbitration checker
   concurrent assertions on the memory port and on response routing */

`timescale 1ns/1ps

`include "mem_arb_cfg.svh"

module dual_core_mem_arbiter_chk
	import mem_arb_pkg::*;
(
	input	logic						clk,
	input	logic						rst,
	input	imem_req_t					core0_req_i,
	input	imem_req_t					core1_req_i,
	input	dmem_req_t					dmem_req_i,
	input	mem_cmd_e					mem_cmd_i,
	input	logic	[`MEM_DATA_W-1:0]	mem_data_i,
	input	logic	[`MEM_TAG_W-1:0]	core0_response_i,
	input	logic	[`MEM_TAG_W-1:0]	core1_response_i,
	input	logic	[`MEM_TAG_W-1:0]	dmem_response_i
);

	// number of failed assertions
	int unsigned	fail_cnt = 0;

	logic	both_core_req;
	logic	all_idle;

	assign both_core_req = (core0_req_i.cmd != MEM_NONE) && (core1_req_i.cmd != MEM_NONE);
	assign all_idle = (core0_req_i.cmd == MEM_NONE) && (core1_req_i.cmd == MEM_NONE)
		&& (dmem_req_i.cmd == MEM_NONE);

	//--------------------------------------------------
	// port and routing properties
	//--------------------------------------------------
	one_response: assert property (@(posedge clk)
		$onehot0({|core0_response_i, |core1_response_i, |dmem_response_i}))
		else begin
			$error("more than one response output carries a tag");
			fail_cnt++;
		end

	idle_port: assert property (@(posedge clk) all_idle |-> (mem_cmd_i == MEM_NONE))
		else begin
			$error("memory command issued with no request present");
			fail_cnt++;
		end

	store_data: assert property (@(posedge clk) mem_data_i == dmem_req_i.data)
		else begin
			$error("memory data differs from the data side store data");
			fail_cnt++;
		end

	// loser of contended fetches alternates every cycle
	core0_yields: assert property (@(posedge clk) disable iff (rst)
		(both_core_req && $past(both_core_req) && !$past(rst) && $past(core0_response_i) != '0)
		|-> (core0_response_i == '0))
		else begin
			$error("core0 served in two contended cycles in a row");
			fail_cnt++;
		end

	core1_yields: assert property (@(posedge clk) disable iff (rst)
		(both_core_req && $past(both_core_req) && !$past(rst) && $past(core1_response_i) != '0)
		|-> (core1_response_i == '0))
		else begin
			$error("core1 served in two contended cycles in a row");
			fail_cnt++;
		end

endmodule : dual_core_mem_arbiter_chk

bind dual_core_mem_arbiter dual_core_mem_arbiter_chk chk (
	.clk				(clk),
	.rst				(rst),
	.core0_req_i		(core0_imem_req_i),
	.core1_req_i		(core1_imem_req_i),
	.dmem_req_i			(dmem_req_i),
	.mem_cmd_i			(mem_cmd_o),
	.mem_data_i			(mem_data_o),
	.core0_response_i	(core0_response_o),
	.core1_response_i	(core1_response_o),
	.dmem_response_i	(dmem_response_o)
);

// File: rtl/dual_core_mem_arbiter.sv
/* dual core memory arbiter
   shares one memory port among two instruction fetch units and the data controller */

`timescale 1ns/1ps

`include "mem_arb_cfg.svh"

module dual_core_mem_arbiter
	import mem_arb_pkg::*;
(
	input	logic						clk,
	input	logic						rst,

	// requesters
	input	imem_req_t					core0_imem_req_i,
	input	imem_req_t					core1_imem_req_i,
	input	dmem_req_t					dmem_req_i,

	// memory side
	input	logic	[`MEM_TAG_W-1:0]	mem_response_i,
	output	mem_cmd_e					mem_cmd_o,
	output	logic	[`MEM_ADDR_W-1:0]	mem_addr_o,
	output	logic	[`MEM_DATA_W-1:0]	mem_data_o,

	// per requester response tags
	output	logic	[`MEM_TAG_W-1:0]	core0_response_o,
	output	logic	[`MEM_TAG_W-1:0]	core1_response_o,
	output	logic	[`MEM_TAG_W-1:0]	dmem_response_o
);

	//--------------------------------------------------
	// between the two arbiters
	//--------------------------------------------------
	imem_req_t					imem_req;
	logic	[`MEM_TAG_W-1:0]	imem_response;

	// first level, core0 vs core1 fetch
	imem_port_arbiter imem_arb (
		.clk				(clk),
		.rst				(rst),
		.core0_req_i		(core0_imem_req_i),
		.core1_req_i		(core1_imem_req_i),
		.req_o				(imem_req),
		.response_i			(imem_response),
		.core0_response_o	(core0_response_o),
		.core1_response_o	(core1_response_o)
	);

	// second level, fetch winner vs data
	mem_port_arbiter mem_arb (
		.clk				(clk),
		.rst				(rst),
		.imem_req_i			(imem_req),
		.dmem_req_i			(dmem_req_i),
		.mem_response_i		(mem_response_i),
		.mem_cmd_o			(mem_cmd_o),
		.mem_addr_o			(mem_addr_o),
		.mem_data_o			(mem_data_o),
		.imem_response_o	(imem_response),
		.dmem_response_o	(dmem_response_o)
	);

endmodule : dual_core_mem_arbiter

// File: rtl/mem_port_arbiter.sv
/* memory port arbiter
   picks instruction or data request by a rotating priority vector and drives the memory port */

`timescale 1ns/1ps

`include "mem_arb_cfg.svh"

module mem_port_arbiter
	import mem_arb_pkg::*;
(
	input	logic						clk,
	input	logic						rst,

	// instruction winner and data controller requests
	input	imem_req_t					imem_req_i,
	input	dmem_req_t					dmem_req_i,

	// response tag from memory
	input	logic	[`MEM_TAG_W-1:0]	mem_response_i,

	// shared memory port
	output	mem_cmd_e					mem_cmd_o,
	output	logic	[`MEM_ADDR_W-1:0]	mem_addr_o,
	output	logic	[`MEM_DATA_W-1:0]	mem_data_o,

	// tag back to each side
	output	logic	[`MEM_TAG_W-1:0]	imem_response_o,
	output	logic	[`MEM_TAG_W-1:0]	dmem_response_o
);

	localparam int ABT_VEC_W = `MEM_ABT_PERIOD;

	//--------------------------------------------------
	// rotating priority vector
	//--------------------------------------------------
	// one-hot, bit 0 set means instruction fetch has first claim
	logic	[ABT_VEC_W-1:0]	abt_vec_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			abt_vec_r <= {{(ABT_VEC_W-1){1'b0}}, 1'b1};
		end else begin
			// rotate right by one each cycle
			abt_vec_r <= {abt_vec_r[0], abt_vec_r[ABT_VEC_W-1:1]};
		end
	end

	//--------------------------------------------------
	// grant
	//--------------------------------------------------
	logic	imem_vld;
	logic	dmem_vld;
	logic	imem_gnt;
	logic	dmem_gnt;

	assign imem_vld = (imem_req_i.cmd != MEM_NONE);
	assign dmem_vld = (dmem_req_i.cmd != MEM_NONE);

	always_comb begin
		imem_gnt = 1'b0;
		dmem_gnt = 1'b0;
		if (abt_vec_r[0]) begin
			// instruction slot
			imem_gnt = imem_vld;
			dmem_gnt = dmem_vld & ~imem_vld;
		end else begin
			// data slot, three of every period
			dmem_gnt = dmem_vld;
			imem_gnt = imem_vld & ~dmem_vld;
		end
	end

	//--------------------------------------------------
	// memory port
	//--------------------------------------------------
	always_comb begin
		if (dmem_gnt) begin
			mem_cmd_o	= dmem_req_i.cmd;
			mem_addr_o	= dmem_req_i.addr;
		end else begin
			// also the idle case, instruction cmd is MEM_NONE then
			mem_cmd_o	= imem_req_i.cmd;
			mem_addr_o	= imem_req_i.addr;
		end
	end

	// only the data side ever writes
	assign mem_data_o = dmem_req_i.data;

	//--------------------------------------------------
	// response split
	//--------------------------------------------------
	assign imem_response_o = imem_gnt ? mem_response_i : '0;
	assign dmem_response_o = dmem_gnt ? mem_response_i : '0;

endmodule : mem_port_arbiter

// File: rtl/imem_port_arbiter.sv
/* instruction request arbiter
   picks one of two cores' fetch requests by a toggling priority bit, routes the tag back */

`timescale 1ns/1ps

`include "mem_arb_cfg.svh"

module imem_port_arbiter
	import mem_arb_pkg::*;
(
	input	logic						clk,
	input	logic						rst,

	// fetch requests from the two cores
	input	imem_req_t					core0_req_i,
	input	imem_req_t					core1_req_i,

	// winning request towards the I/D arbiter
	output	imem_req_t					req_o,

	// response tag from the I/D arbiter
	input	logic	[`MEM_TAG_W-1:0]	response_i,
	output	logic	[`MEM_TAG_W-1:0]	core0_response_o,
	output	logic	[`MEM_TAG_W-1:0]	core1_response_o
);

	//--------------------------------------------------
	// priority bit
	//--------------------------------------------------
	// 0 gives core0 first claim, 1 gives core1 first claim
	logic	core1_first_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			core1_first_r <= 1'b0;
		end else begin
			// flips every cycle, requests or not
			core1_first_r <= ~core1_first_r;
		end
	end

	//--------------------------------------------------
	// grant
	//--------------------------------------------------
	logic	core0_vld;
	logic	core1_vld;
	logic	core0_gnt;
	logic	core1_gnt;

	assign core0_vld = (core0_req_i.cmd != MEM_NONE);
	assign core1_vld = (core1_req_i.cmd != MEM_NONE);

	always_comb begin
		core0_gnt = 1'b0;
		core1_gnt = 1'b0;
		if (core1_first_r) begin
			// core1 preferred
			core1_gnt = core1_vld;
			core0_gnt = core0_vld & ~core1_vld;
		end else begin
			// core0 preferred
			core0_gnt = core0_vld;
			core1_gnt = core1_vld & ~core0_vld;
		end
	end

	//--------------------------------------------------
	// request forward and response split
	//--------------------------------------------------
	// idle case forwards core0, whose command is MEM_NONE then
	assign req_o = core1_gnt ? core1_req_i : core0_req_i;

	// tag goes only to the core that was granted
	assign core0_response_o = core0_gnt ? response_i : '0;
	assign core1_response_o = core1_gnt ? response_i : '0;

endmodule : imem_port_arbiter

// File: rtl/mem_arb_pkg.sv
/* memory arbiter types
   command encoding and the request bundles of the instruction and data sides */

`include "mem_arb_cfg.svh"

package mem_arb_pkg;

	//--------------------------------------------------
	// memory command
	//--------------------------------------------------
	typedef enum logic [1:0] {
		MEM_NONE	= 2'd0,
		MEM_LOAD	= 2'd1,
		MEM_STORE	= 2'd2
	} mem_cmd_e;

	//--------------------------------------------------
	// request bundles
	//--------------------------------------------------
	// instruction fetch request, one per core plus the winner
	typedef struct packed {
		mem_cmd_e					cmd;
		logic	[`MEM_ADDR_W-1:0]	addr;
	} imem_req_t;

	// data controller request, carries store data
	typedef struct packed {
		mem_cmd_e					cmd;
		logic	[`MEM_ADDR_W-1:0]	addr;
		logic	[`MEM_DATA_W-1:0]	data;
	} dmem_req_t;

endpackage : mem_arb_pkg

// File: include/mem_arb_cfg.svh
/* memory arbiter configuration
   port widths of the shared memory port and the length of the I/D priority rotation */

`ifndef MEM_ARB_CFG_SVH
`define MEM_ARB_CFG_SVH

// memory address width
`define MEM_ADDR_W		64

// store data width, data side only
`define MEM_DATA_W		64

// response tag width, zero tag means no response
`define MEM_TAG_W		4

// instruction/data rotation length
// instruction fetch has first claim in one slot of each period
`define MEM_ABT_PERIOD	4

`endif
